// File: Makefile
TOP := tb_addr_remap
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: addr_remap_asserts.sv
// Pipeline assertions for the address remap unit
// Bound into the top level, covers latency, miss handling and the fault tally
`timescale 1ns/100ps

module addr_remap_asserts
(
	input logic                       clk,
	input logic                       arst_n,
	input logic                       req_valid,
	input logic                       resp_valid,
	input logic                       dec_valid,
	input addr_remap_pkg::decode_t    dec,
	input addr_remap_pkg::resp_t      exe,
	input logic                       fault_clear,
	input addr_remap_pkg::fault_cnt_t fault_count
);

	// Three register stages from request to response
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		resp_valid == $past(req_valid, 3))
		else $error("resp_valid is not req_valid delayed by 3 cycles");

	// A decode miss must leave execute as a fault
	a_miss_faults: assert property (@(posedge clk) disable iff (!arst_n)
		(dec_valid && !dec.hit) |=> (exe.fault != addr_remap_pkg::FAULT_NONE))
		else $error("decode miss produced a fault free response");

	// Tally only moves down through a clear
	a_count_up: assert property (@(posedge clk) disable iff (!arst_n)
		!fault_clear |=> (fault_count >= $past(fault_count)))
		else $error("fault_count decreased without fault_clear");

endmodule

bind addr_remap_top addr_remap_asserts u_asserts (
	.clk         (clk),
	.arst_n      (arst_n),
	.req_valid   (req_valid),
	.resp_valid  (resp_valid),
	.dec_valid   (dec_valid),
	.dec         (dec),
	.exe         (exe),
	.fault_clear (fault_clear),
	.fault_count (fault_count)
);

// File: addr_remap_pkg.sv
// Address remap package
// Shared types for the region table, the remap pipeline and its responses
package addr_remap_pkg;

	// **********************************************************************
	// Plain vector widths
	// **********************************************************************

	// Bus address, fixed at 32 bits
	typedef logic [31:0] addr_t;

	// Saturating fault tally
	typedef logic [15:0] fault_cnt_t;

	// **********************************************************************
	// Enumerations
	// **********************************************************************

	// Outcome of a remap request
	typedef enum logic [1:0] {
		FAULT_NONE       = 2'd0,
		FAULT_MISS       = 2'd1,
		FAULT_WRITE_PROT = 2'd2
	} fault_t;

	// Field targeted by a configuration write
	// FLAGS carries enable in bit 0 and writable in bit 1
	typedef enum logic [1:0] {
		CFG_BASE   = 2'd0,
		CFG_LAST   = 2'd1,
		CFG_OFFSET = 2'd2,
		CFG_FLAGS  = 2'd3
	} cfg_field_t;

	// **********************************************************************
	// Packed structs
	// **********************************************************************

	// One programmable region, last bound is inclusive
	typedef struct packed {
		addr_t base;
		addr_t last;
		addr_t offset;
		logic  enable;
		logic  writable;
	} region_cfg_t;

	// Incoming request
	typedef struct packed {
		addr_t addr;
		logic  write;
	} req_t;

	// Decode stage to execute stage
	typedef struct packed {
		req_t        req;
		logic        hit;
		region_cfg_t sel;
	} decode_t;

	// Execute stage to result stage and out of the block
	typedef struct packed {
		addr_t  addr;
		logic   write;
		fault_t fault;
	} resp_t;

endpackage

// File: addr_remap_top.sv
// Address remap unit
// Region table feeding a three stage decode, execute and result pipeline
`timescale 1ns/100ps

module addr_remap_top
#(
	parameter int NUM_REGION = 4,
	parameter int GRANULE    = 128
)
(
	input  logic                              clk,
	input  logic                              arst_n,
	// Configuration port
	input  logic                              cfg_wr,
	input  logic [$clog2(NUM_REGION+1)-1:0]   cfg_index,
	input  addr_remap_pkg::cfg_field_t        cfg_field,
	input  addr_remap_pkg::addr_t             cfg_data,
	// Request and response
	input  logic                              req_valid,
	input  addr_remap_pkg::req_t              req,
	output logic                              resp_valid,
	output addr_remap_pkg::resp_t             resp,
	// Fault bookkeeping
	input  logic                              fault_clear,
	output addr_remap_pkg::fault_cnt_t        fault_count,
	output logic                              first_fault_valid,
	output addr_remap_pkg::addr_t             first_fault_addr
);

	addr_remap_pkg::region_cfg_t [NUM_REGION-1:0] regions;
	logic                                         dec_valid;
	addr_remap_pkg::decode_t                      dec;
	logic                                         exe_valid;
	addr_remap_pkg::resp_t                        exe;

	// **********************************************************************
	// Table and pipeline stages
	// **********************************************************************

	region_table #(
		.NUM_REGION (NUM_REGION)
	) u_table (
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg_wr    (cfg_wr),
		.cfg_index (cfg_index),
		.cfg_field (cfg_field),
		.cfg_data  (cfg_data),
		.regions   (regions)
	);

	region_decoder #(
		.NUM_REGION (NUM_REGION),
		.GRANULE    (GRANULE)
	) u_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req       (req),
		.regions   (regions),
		.dec_valid (dec_valid),
		.dec       (dec)
	);

	remap_execute u_execute (
		.clk       (clk),
		.arst_n    (arst_n),
		.dec_valid (dec_valid),
		.dec       (dec),
		.exe_valid (exe_valid),
		.exe       (exe)
	);

	remap_result u_result (
		.clk               (clk),
		.arst_n            (arst_n),
		.exe_valid         (exe_valid),
		.exe               (exe),
		.fault_clear       (fault_clear),
		.resp_valid        (resp_valid),
		.resp              (resp),
		.fault_count       (fault_count),
		.first_fault_valid (first_fault_valid),
		.first_fault_addr  (first_fault_addr)
	);

endmodule

// File: files.f
addr_remap_pkg.sv
region_table.sv
region_decoder.sv
remap_execute.sv
remap_result.sv
addr_remap_top.sv
addr_remap_asserts.sv
tb_addr_remap.sv

// File: region_decoder.sv
// Region decoder
// Decode stage, matches a request against all regions and picks the winner
`timescale 1ns/100ps

module region_decoder
#(
	parameter int NUM_REGION = 4,
	parameter int GRANULE    = 128
)
(
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  logic                                         req_valid,
	input  addr_remap_pkg::req_t                         req,
	input  addr_remap_pkg::region_cfg_t [NUM_REGION-1:0] regions,
	output logic                                         dec_valid,
	output addr_remap_pkg::decode_t                      dec
);

	localparam int ADDR_W    = $bits(addr_remap_pkg::addr_t);
	// Bits below the granule take no part in the compare
	localparam int GRAN_BITS = $clog2(GRANULE);

	logic [ADDR_W-1:GRAN_BITS]   req_gran;
	logic [NUM_REGION-1:0]       above_base;
	logic [NUM_REGION-1:0]       below_last;
	logic [NUM_REGION-1:0]       match;
	logic                        hit;
	addr_remap_pkg::region_cfg_t sel;

	// **********************************************************************
	// Bound compare at granule resolution
	// **********************************************************************

	assign req_gran = req.addr[ADDR_W-1:GRAN_BITS];

	for (genvar i = 0; i < NUM_REGION; i++)
	begin : g_match
		assign above_base[i] = (req_gran >= regions[i].base[ADDR_W-1:GRAN_BITS]);
		assign below_last[i] = (req_gran <= regions[i].last[ADDR_W-1:GRAN_BITS]);
		// Disabled entries never match
		assign match[i] = regions[i].enable && above_base[i] && below_last[i];
	end

	// **********************************************************************
	// Priority select
	// **********************************************************************

	assign hit = |match;

	// Walk from the top so the lowest matching index is written last
	always_comb
	begin
		sel = '0;
		for (int i = NUM_REGION - 1; i >= 0; i--)
		begin
			if (match[i])
			begin
				sel = regions[i];
			end
		end
	end

	// Stage register
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dec_valid <= 1'b0;
		end
		else
		begin
			dec_valid <= req_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		dec.req <= req;
		dec.hit <= hit;
		dec.sel <= sel;
	end

endmodule

// File: region_table.sv
// Region table
// Register file of remap regions, one field updated per configuration strobe
`timescale 1ns/100ps

module region_table
#(
	parameter int NUM_REGION = 4
)
(
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  logic                                         cfg_wr,
	input  logic [$clog2(NUM_REGION+1)-1:0]              cfg_index,
	input  addr_remap_pkg::cfg_field_t                   cfg_field,
	input  addr_remap_pkg::addr_t                        cfg_data,
	output addr_remap_pkg::region_cfg_t [NUM_REGION-1:0] regions
);

	// Index is one bit wider than needed so out of range values exist
	localparam int IDX_W = $clog2(NUM_REGION + 1);

	// Table storage
	addr_remap_pkg::region_cfg_t [NUM_REGION-1:0] entries;

	// **********************************************************************
	// Configuration write
	// **********************************************************************

	// Reset leaves every region disabled
	// An index that matches no entry falls through untouched
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			entries <= '0;
		end
		else if (cfg_wr)
		begin
			for (int i = 0; i < NUM_REGION; i++)
			begin
				if (cfg_index == IDX_W'(i))
				begin
					case (cfg_field)
						addr_remap_pkg::CFG_BASE:
						begin
							entries[i].base <= cfg_data;
						end
						addr_remap_pkg::CFG_LAST:
						begin
							entries[i].last <= cfg_data;
						end
						addr_remap_pkg::CFG_OFFSET:
						begin
							entries[i].offset <= cfg_data;
						end
						addr_remap_pkg::CFG_FLAGS:
						begin
							// Only the two low bits are meaningful
							entries[i].enable   <= cfg_data[0];
							entries[i].writable <= cfg_data[1];
						end
					endcase
				end
			end
		end
	end

	// Whole table is visible to the decoder every cycle
	assign regions = entries;

endmodule

// File: remap_execute.sv
// Remap execute stage
// Applies the region offset, checks write permission and classifies faults
`timescale 1ns/100ps

module remap_execute
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    dec_valid,
	input  addr_remap_pkg::decode_t dec,
	output logic                    exe_valid,
	output addr_remap_pkg::resp_t   exe
);

	addr_remap_pkg::addr_t  xlate_addr;
	addr_remap_pkg::fault_t fault;
	addr_remap_pkg::addr_t  out_addr;

	// **********************************************************************
	// Translation and fault classification
	// **********************************************************************

	// Full address plus offset, wraps modulo 2^32
	assign xlate_addr = dec.req.addr + dec.sel.offset;

	// Miss wins over permission, sel is zero on a miss anyway
	always_comb
	begin
		if (!dec.hit)
		begin
			fault = addr_remap_pkg::FAULT_MISS;
		end
		else if (dec.req.write && !dec.sel.writable)
		begin
			fault = addr_remap_pkg::FAULT_WRITE_PROT;
		end
		else
		begin
			fault = addr_remap_pkg::FAULT_NONE;
		end
	end

	// A faulting request keeps its original address
	assign out_addr = (fault == addr_remap_pkg::FAULT_NONE) ? xlate_addr : dec.req.addr;

	// Stage register
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			exe_valid <= 1'b0;
		end
		else
		begin
			exe_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		exe.addr  <= out_addr;
		exe.write <= dec.req.write;
		exe.fault <= fault;
	end

endmodule

// File: remap_result.sv
// Remap result stage
// Registers the response, tallies faults and holds the first fault address
`timescale 1ns/100ps

module remap_result
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       exe_valid,
	input  addr_remap_pkg::resp_t      exe,
	input  logic                       fault_clear,
	output logic                       resp_valid,
	output addr_remap_pkg::resp_t      resp,
	output addr_remap_pkg::fault_cnt_t fault_count,
	output logic                       first_fault_valid,
	output addr_remap_pkg::addr_t      first_fault_addr
);

	logic is_fault;
	logic capture;

	assign is_fault = exe_valid && (exe.fault != addr_remap_pkg::FAULT_NONE);
	// Only the first fault after reset or clear is latched
	assign capture  = is_fault && !first_fault_valid && !fault_clear;

	// **********************************************************************
	// Output register and fault bookkeeping
	// **********************************************************************

	// Clear beats a fault arriving in the same cycle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			resp_valid        <= 1'b0;
			fault_count       <= '0;
			first_fault_valid <= 1'b0;
		end
		else
		begin
			resp_valid <= exe_valid;
			if (fault_clear)
			begin
				fault_count       <= '0;
				first_fault_valid <= 1'b0;
			end
			else if (is_fault)
			begin
				// Saturate at all ones
				if (fault_count != '1)
				begin
					fault_count <= fault_count + 1'b1;
				end
				first_fault_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		resp <= exe;
		if (capture)
		begin
			first_fault_addr <= exe.addr;
		end
	end

endmodule

// File: tb_addr_remap.sv
// Testbench for the address remap unit
// Seeded random regions and requests, checked against a reference model
`timescale 1ns/100ps

module tb_addr_remap;

	localparam int NUM_REGION = 4;
	localparam int GRANULE    = 128;
	localparam int IDX_W      = $clog2(NUM_REGION + 1);
	localparam int GB         = $clog2(GRANULE);
	// Requests per phase, the watchdog budget is built from their sum
	localparam int N_RESET   = 8;
	localparam int N_HIT     = 200;
	localparam int N_BOUND   = 6 * NUM_REGION;
	localparam int N_PRIO    = 80;
	localparam int N_STREAM  = 300;
	localparam int N_BOOK    = 40;
	localparam int N_TOTAL   = N_RESET + N_HIT + N_BOUND + N_PRIO + N_STREAM + N_BOOK;
	localparam int WD_CYCLES = N_TOTAL * 10 + 500;

	logic                       clk = 1'b0;
	logic                       arst_n;
	logic                       cfg_wr;
	logic [IDX_W-1:0]           cfg_index;
	addr_remap_pkg::cfg_field_t cfg_field;
	addr_remap_pkg::addr_t      cfg_data;
	logic                       req_valid;
	addr_remap_pkg::req_t       req;
	logic                       fault_clear;
	logic                       resp_valid;
	addr_remap_pkg::resp_t      resp;
	addr_remap_pkg::fault_cnt_t fault_count;
	logic                       first_fault_valid;
	addr_remap_pkg::addr_t      first_fault_addr;

	// Reference model, a mirror of the table and the expected responses in order
	addr_remap_pkg::region_cfg_t model_tbl [NUM_REGION];
	addr_remap_pkg::resp_t       exp_q [$];
	int                          issue_q [$];
	int                          cycle_cnt = 0;
	int                          model_count = 0;
	logic                        model_first_valid = 1'b0;
	addr_remap_pkg::addr_t       model_first_addr;
	string                       test_name = "reset_state";
	// Where each region was placed, used to aim requests
	addr_remap_pkg::addr_t       reg_base [NUM_REGION];
	int unsigned                 reg_span [NUM_REGION];

	addr_remap_top #(.NUM_REGION(NUM_REGION), .GRANULE(GRANULE)) uut (.*);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle_cnt++;

	// **********************************************************************
	// Helpers
	// **********************************************************************

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_equal(string what, logic [31:0] expd, logic [31:0] act);
		assert (expd === act)
		else
		begin
			$display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h", test_name, what, expd, act);
			abort_run();
		end
	endtask

	// Lowest enabled region whose bounds hold the address, bits below the granule ignored
	function automatic addr_remap_pkg::resp_t predict(addr_remap_pkg::addr_t addr, logic write);
		addr_remap_pkg::resp_t r;
		int win;
		win = -1;
		for (int i = 0; i < NUM_REGION; i++)
			if (win < 0 && model_tbl[i].enable && (addr >> GB) >= (model_tbl[i].base >> GB)
				&& (addr >> GB) <= (model_tbl[i].last >> GB))
				win = i;
		r.addr  = addr;
		r.write = write;
		if (win < 0)
			r.fault = addr_remap_pkg::FAULT_MISS;
		else if (write && !model_tbl[win].writable)
			r.fault = addr_remap_pkg::FAULT_WRITE_PROT;
		else
		begin
			r.fault = addr_remap_pkg::FAULT_NONE;
			r.addr  = addr + model_tbl[win].offset;
		end
		return r;
	endfunction

	// Strobes drop each cycle unless a task raises them again
	task automatic next_cycle();
		@(posedge clk);
		#1;
		cfg_wr      = 1'b0;
		req_valid   = 1'b0;
		fault_clear = 1'b0;
	endtask

	task automatic write_cfg(int idx, addr_remap_pkg::cfg_field_t field, addr_remap_pkg::addr_t data);
		next_cycle();
		cfg_wr    = 1'b1;
		cfg_index = IDX_W'(idx);
		cfg_field = field;
		cfg_data  = data;
		// Out of range index leaves the mirror alone too
		if (idx < NUM_REGION)
			case (field)
				addr_remap_pkg::CFG_BASE:   model_tbl[idx].base   = data;
				addr_remap_pkg::CFG_LAST:   model_tbl[idx].last   = data;
				addr_remap_pkg::CFG_OFFSET: model_tbl[idx].offset = data;
				default:                    {model_tbl[idx].writable, model_tbl[idx].enable} = data[1:0];
			endcase
	endtask

	task automatic send_request(addr_remap_pkg::addr_t addr, logic write);
		next_cycle();
		req_valid = 1'b1;
		req.addr  = addr;
		req.write = write;
		exp_q.push_back(predict(addr, write));
		issue_q.push_back(cycle_cnt);
	endtask

	task automatic drain();
		next_cycle();
		while (exp_q.size() != 0)
			next_cycle();
	endtask

	task automatic clear_faults();
		next_cycle();
		fault_clear = 1'b1;
		next_cycle();
		model_count       = 0;
		model_first_valid = 1'b0;
	endtask

	// One region per quarter of the address space, granule aligned, enabled
	task automatic place_regions(bit rand_perm);
		for (int i = 0; i < NUM_REGION; i++)
		begin
			reg_span[i] = (($urandom % 64) + 1) * GRANULE;
			reg_base[i] = (addr_remap_pkg::addr_t'(i) << 30) + (($urandom % 4096) + 1) * GRANULE;
			write_cfg(i, addr_remap_pkg::CFG_BASE, reg_base[i]);
			write_cfg(i, addr_remap_pkg::CFG_LAST, reg_base[i] + reg_span[i] - 1);
			write_cfg(i, addr_remap_pkg::CFG_OFFSET, $urandom);
			write_cfg(i, addr_remap_pkg::CFG_FLAGS, {30'd0, rand_perm ? 1'($urandom) : 1'b1, 1'b1});
		end
	endtask

	// **********************************************************************
	// Response monitor, outputs sampled on the falling edge
	// **********************************************************************

	always @(negedge clk)
	begin
		addr_remap_pkg::resp_t expd;
		int issued;
		if (arst_n && resp_valid)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				$display("A response came out with no request outstanding in %s", test_name);
				abort_run();
			end
			expd   = exp_q.pop_front();
			issued = issue_q.pop_front();
			check_equal("latency", 3, cycle_cnt - issued);
			check_equal("address", expd.addr, resp.addr);
			check_equal("write", 32'(expd.write), 32'(resp.write));
			check_equal("fault", 32'(expd.fault), 32'(resp.fault));
			if (expd.fault != addr_remap_pkg::FAULT_NONE)
			begin
				if (model_count < 65535)
					model_count++;
				if (!model_first_valid)
				begin
					model_first_valid = 1'b1;
					model_first_addr  = expd.addr;
				end
			end
		end
		if (arst_n)
		begin
			check_equal("fault count", model_count, 32'(fault_count));
			check_equal("first fault valid", 32'(model_first_valid), 32'(first_fault_valid));
			if (model_first_valid)
				check_equal("first fault address", model_first_addr, first_fault_addr);
		end
	end

	// Ten cycles per request plus room for reset and configuration
	initial
	begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
		abort_run();
	end

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial
	begin
		addr_remap_pkg::addr_t addr;
		int r;
		void'($urandom(94));
		arst_n      = 1'b0;
		cfg_wr      = 1'b0;
		cfg_index   = '0;
		cfg_field   = addr_remap_pkg::CFG_BASE;
		cfg_data    = '0;
		req_valid   = 1'b0;
		req         = '0;
		fault_clear = 1'b0;
		for (int i = 0; i < NUM_REGION; i++)
			model_tbl[i] = '0;
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;

		// Nothing configured, so every request misses
		check_equal("resp_valid", 0, 32'(resp_valid));
		check_equal("fault_count", 0, 32'(fault_count));
		check_equal("first_fault_valid", 0, 32'(first_fault_valid));
		repeat (N_RESET) send_request($urandom, 1'($urandom));
		drain();

		test_name = "translate_hit";
		place_regions(1'b0);
		for (int n = 0; n < N_HIT; n++)
		begin
			r = $urandom % NUM_REGION;
			send_request(reg_base[r] + ($urandom % reg_span[r]), 1'($urandom));
		end
		drain();

		// Edges of each region, one granule either side
		test_name = "granule_bounds";
		// Base and last moved off the granule grid inside their end granules
		for (int i = 0; i < NUM_REGION; i++)
		begin
			write_cfg(i, addr_remap_pkg::CFG_BASE, reg_base[i] + GRANULE - 1);
			write_cfg(i, addr_remap_pkg::CFG_LAST, reg_base[i] + reg_span[i] - GRANULE);
		end
		for (int i = 0; i < NUM_REGION; i++)
		begin
			send_request(reg_base[i], 1'b0);
			send_request(reg_base[i] - 1, 1'b0);
			send_request(reg_base[i] - GRANULE, 1'b1);
			send_request(reg_base[i] + reg_span[i] - GRANULE, 1'b1);
			send_request(reg_base[i] + reg_span[i] - 1, 1'b0);
			send_request(reg_base[i] + reg_span[i] - 1 + GRANULE, 1'b0);
		end
		drain();

		// Region 0 read only inside region 1, region 3 wider than both
		test_name = "priority_permission";
		write_cfg(1, addr_remap_pkg::CFG_LAST, reg_base[1] + 64 * GRANULE - 1);
		write_cfg(0, addr_remap_pkg::CFG_BASE, reg_base[1]);
		write_cfg(0, addr_remap_pkg::CFG_LAST, reg_base[1] + 16 * GRANULE - 1);
		write_cfg(0, addr_remap_pkg::CFG_OFFSET, $urandom);
		write_cfg(0, addr_remap_pkg::CFG_FLAGS, 32'd1);
		write_cfg(3, addr_remap_pkg::CFG_BASE, reg_base[1] - 8 * GRANULE);
		write_cfg(3, addr_remap_pkg::CFG_LAST, reg_base[1] + 128 * GRANULE - 1);
		// Region 2 writable but disabled, then a write past the end of the table
		write_cfg(2, addr_remap_pkg::CFG_FLAGS, 32'd2);
		write_cfg(NUM_REGION, addr_remap_pkg::CFG_FLAGS, 32'd3);
		for (int n = 0; n < N_PRIO; n++)
		begin
			if (n == N_PRIO * 3 / 4)
			begin
				// Region 0 range falls through to region 1
				drain();
				write_cfg(0, addr_remap_pkg::CFG_FLAGS, 32'd0);
			end
			if (n % 4 == 3)
				addr = reg_base[2] + ($urandom % reg_span[2]);
			else
				addr = reg_base[1] - 8 * GRANULE + ($urandom % (136 * GRANULE));
			send_request(addr, 1'($urandom));
		end
		drain();

		// Mixed hits and misses on consecutive cycles
		test_name = "back_to_back";
		place_regions(1'b1);
		for (int n = 0; n < N_STREAM; n++)
		begin
			r = $urandom % NUM_REGION;
			addr = (n % 3 == 0) ? $urandom : reg_base[r] + ($urandom % reg_span[r]);
			send_request(addr, 1'($urandom));
		end
		drain();

		test_name = "fault_bookkeeping";
		clear_faults();
		check_equal("count after clear", 0, 32'(fault_count));
		check_equal("first valid after clear", 0, 32'(first_fault_valid));
		for (int n = 0; n < N_BOOK; n++)
		begin
			r = $urandom % NUM_REGION;
			addr = (n % 5 == 2) ? reg_base[r] - GRANULE : reg_base[r] + ($urandom % reg_span[r]);
			send_request(addr, 1'b0);
		end
		drain();

		if (exp_q.size() == 0 && model_first_valid)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
		begin
			$display("Run ended with responses outstanding or no fault captured after clear");
			abort_run();
		end
	end

endmodule
